// ==== verilog.f ====
+incdir+logic
logic/uno_pkg.sv
logic/uno_hand_store.sv
logic/uno_play_select.sv
logic/uno_turn_ctrl.sv
logic/uno_player.sv
verif/uno_player_assertions.sv
verif/uno_player_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the UNO player testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
    --top-module uno_player_tb -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vuno_player_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

// ==== verif/uno_player_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uno_defs.svh"

module uno_player_tb;

    localparam int CYCLE_LIMIT = 2000; // all tests take about 200 cycles with worst back-pressure

    logic                      i_clk = 1'b0;
    logic                      i_rst_n;
    logic                      i_deal;
    logic                      i_turn_valid;
    uno_pkg::turn_req_t        i_turn;
    logic                      o_turn_ready;
    logic                      o_draw_req;
    logic                      i_draw_valid;
    uno_pkg::card_t            i_draw_card;
    logic                      o_play_valid;
    uno_pkg::card_t            o_play_card;
    logic                      i_play_ready;
    logic [`UNO_COUNT_W-1:0]   o_hand_count;

    uno_pkg::card_t            deck_q[$];                 // front is the next card dealt
    uno_pkg::card_t            ref_card [`UNO_HAND_SLOTS];
    logic                      ref_used [`UNO_HAND_SLOTS];
    int                        ref_count;
    int                        n_draws;
    int                        n_plays;
    int                        act_cycle;                 // first cycle with draw or play
    uno_pkg::card_t            last_played;
    int                        errors;
    int                        checks;
    int                        tests;
    int                        cycle_cnt = 0;

    uno_player dut_i (.*);

    bind uno_player uno_player_assertions checks_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_turn_ready (o_turn_ready),
        .o_draw_req   (o_draw_req),
        .o_play_valid (o_play_valid),
        .o_play_card  (o_play_card),
        .i_play_ready (i_play_ready)
    );

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, a handshake never completed", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic uno_pkg::card_t make_card(input int col, input int rank);
        uno_pkg::card_t c;
        c = {col[1:0], rank[3:0]};
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    function automatic void model_insert(input uno_pkg::card_t c);
        for (int i = 0; i < `UNO_HAND_SLOTS; i++) begin
            if (!ref_used[i]) begin
                ref_card[i] = c;
                ref_used[i] = 1'b1;
                ref_count++;
                return;
            end
        end
    endfunction

    // priority tiers 1 colour, 2 rank, 3 wild, 4 wild-draw-four
    task automatic model_select(input uno_pkg::card_t top, output logic found,
                                output int idx, output uno_pkg::card_t card);
        int tier;
        int best;
        int cnt [4];
        int major;
        best = 5;
        idx = 0;
        cnt = '{0, 0, 0, 0};
        for (int i = 0; i < `UNO_HAND_SLOTS; i++) begin
            if (ref_used[i]) begin
                tier = 5;
                if (ref_card[i].rank <= 4'd12 && ref_card[i].color == top.color) tier = 1;
                else if (top.rank <= 4'd12 && ref_card[i].rank == top.rank) tier = 2;
                else if (ref_card[i].rank == 4'd13) tier = 3;
                else if (ref_card[i].rank == 4'd14) tier = 4;
                if (tier < best) begin
                    best = tier;
                    idx  = i;
                end
                if (ref_card[i].rank <= 4'd12) cnt[ref_card[i].color]++;
            end
        end
        major = 0;
        for (int c = 1; c < 4; c++) begin
            if (cnt[c] > cnt[major]) major = c;
        end
        found = (best < 5);
        card  = ref_card[idx];
        if (card.rank > 4'd12) card.color = uno_pkg::color_e'(major[1:0]);
    endtask

    // issues a turn or deal, then plays deck and game until ready returns
    task automatic serve_request(input logic deal, input uno_pkg::turn_req_t req,
                                 input logic bp, input int rem_idx);
        int             wait_left;
        int             cyc;
        logic           seen;
        uno_pkg::card_t held;
        n_draws   = 0;
        n_plays   = 0;
        act_cycle = -1;
        seen      = 1'b0;
        held      = '0;
        cyc       = 0;
        check_value("o_turn_ready", o_turn_ready, 1);
        i_deal       = deal;
        i_turn_valid = !deal;
        i_turn       = req;
        @(posedge i_clk);
        #2;
        i_deal       = 1'b0;
        i_turn_valid = 1'b0;
        wait_left    = bp ? int'($urandom % 6) : 0;
        while (!o_turn_ready) begin
            if (act_cycle < 0 && (o_draw_req || o_play_valid)) act_cycle = cyc;
            if (o_draw_req && deck_q.size() == 0) begin
                $display("deck ran out while the player still requested a card");
                errors++;
                break;
            end
            i_draw_valid = o_draw_req;
            i_draw_card  = o_draw_req ? deck_q[0] : '0;
            i_play_ready = 1'b0;
            if (o_play_valid) begin
                if (seen) begin
                    check_value("o_play_card", o_play_card, held);
                end else begin
                    held = o_play_card;
                    seen = 1'b1;
                end
                if (wait_left > 0) begin
                    check_value("o_hand_count", o_hand_count, ref_count); // not yet removed
                    wait_left--;
                end else begin
                    i_play_ready = 1'b1;
                    last_played  = o_play_card;
                end
            end
            @(posedge i_clk);
            #2;
            if (i_draw_valid) begin
                model_insert(deck_q.pop_front());
                n_draws++;
            end
            if (i_play_ready) begin
                ref_used[rem_idx] = 1'b0;
                ref_count--;
                n_plays++;
            end
            cyc++;
        end
        i_draw_valid = 1'b0;
        i_play_ready = 1'b0;
    endtask

    task automatic play_turn(input uno_pkg::card_t top, input logic bp);
        uno_pkg::turn_req_t req;
        logic               found;
        int                 idx;
        uno_pkg::card_t     exp_card;
        req.top     = top;
        req.penalty = uno_pkg::pen_none;
        model_select(top, found, idx, exp_card);
        serve_request(1'b0, req, bp, idx);
        check_value("first action cycle", act_cycle, 1);
        check_value("play count", n_plays, found ? 1 : 0);
        check_value("draw count", n_draws, found ? 0 : 1);
        if (found) check_value("o_play_card", last_played, exp_card);
        check_value("o_hand_count", o_hand_count, ref_count);
    endtask

    task automatic draw_turn(input logic deal, input uno_pkg::penalty_e pen, input int exp_n);
        uno_pkg::turn_req_t req;
        req.top     = make_card(0, 0);
        req.penalty = pen;
        serve_request(deal, req, 1'b0, 0);
        check_value("first action cycle", act_cycle, 0);
        check_value("draw count", n_draws, exp_n);
        check_value("play count", n_plays, 0);
        check_value("o_hand_count", o_hand_count, ref_count);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        $display("test %-16s done, %0d errors", name, errors - errs_before);
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        check_value("o_turn_ready", o_turn_ready, 1);
        check_value("o_draw_req", o_draw_req, 0);
        check_value("o_play_valid", o_play_valid, 0);
        check_value("o_hand_count", o_hand_count, 0);
        finish_test("reset", start);
    endtask

    task automatic test_deal();
        int start;
        start = errors;
        deck_q = '{make_card(0, 5), make_card(1, 3), make_card(2, 7), make_card(0, 14),
                   make_card(0, 13), make_card(1, 9), make_card(1, 11)};
        draw_turn(1'b1, uno_pkg::pen_none, 7);
        check_value("o_hand_count", o_hand_count, 7);
        finish_test("deal", start);
    endtask

    task automatic test_colour_match();
        int start;
        start = errors;
        play_turn(make_card(1, 1), 1'b0);
        check_value("o_play_card", last_played, make_card(1, 3)); // lowest yellow
        finish_test("colour_match", start);
    endtask

    task automatic test_rank_then_wild();
        int start;
        start = errors;
        play_turn(make_card(3, 7), 1'b0);
        check_value("o_play_card", last_played, make_card(2, 7));
        play_turn(make_card(3, 2), 1'b0);
        check_value("o_play_card", last_played, make_card(1, 13)); // yellow is majority
        play_turn(make_card(3, 2), 1'b0);
        check_value("o_play_card", last_played, make_card(1, 14));
        finish_test("rank_then_wild", start);
    endtask

    task automatic test_no_match();
        int start;
        start = errors;
        deck_q = '{make_card(3, 6)};
        play_turn(make_card(3, 4), 1'b0);
        check_value("deck cards left", deck_q.size(), 0);
        finish_test("no_match", start);
    endtask

    task automatic test_penalties();
        int start;
        start = errors;
        deck_q = '{make_card(2, 2), make_card(0, 8)};
        draw_turn(1'b0, uno_pkg::pen_two, 2);
        deck_q = '{make_card(1, 0), make_card(3, 1), make_card(0, 13), make_card(2, 9)};
        draw_turn(1'b0, uno_pkg::pen_four, 4);
        finish_test("penalties", start);
    endtask

    task automatic test_back_pressure();
        int start;
        start = errors;
        play_turn(make_card(0, 3), 1'b1);
        play_turn(make_card(2, 6), 1'b1);
        play_turn(make_card(3, 5), 1'b1);
        play_turn(make_card(0, 12), 1'b1);
        finish_test("back_pressure", start);
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        tests     = 0;
        ref_count = 0;
        for (int i = 0; i < `UNO_HAND_SLOTS; i++) begin
            ref_used[i] = 1'b0;
            ref_card[i] = '0;
        end
        void'($urandom(32'ha64f));
        i_rst_n      = 1'b0;
        i_deal       = 1'b0;
        i_turn_valid = 1'b0;
        i_turn       = '0;
        i_draw_valid = 1'b0;
        i_draw_card  = '0;
        i_play_ready = 1'b0;
        repeat (8) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        test_reset();
        test_deal();
        test_colour_match();
        test_rank_then_wild();
        test_no_match();
        test_penalties();
        test_back_pressure();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/uno_player_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module uno_player_assertions (
    input logic           i_clk,
    input logic           i_rst_n,
    input logic           o_turn_ready,
    input logic           o_draw_req,
    input logic           o_play_valid,
    input uno_pkg::card_t o_play_card,
    input logic           i_play_ready
);

    // a waiting play keeps valid and card until the game takes it
    a_play_stable: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_play_valid && !i_play_ready |=> o_play_valid && $stable(o_play_card)
    ) else $error("play card or valid changed before the play handshake");

    a_one_action: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_draw_req && o_play_valid)
    ) else $error("draw request and play valid high together");

    // no new turn while a draw or play is pending
    a_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_draw_req || o_play_valid) |-> !o_turn_ready
    ) else $error("turn ready high during a draw or play");

endmodule

`default_nettype wire

// ==== logic/uno_player.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uno_defs.svh"

module uno_player (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_deal,
    input  logic                      i_turn_valid,
    input  uno_pkg::turn_req_t        i_turn,
    output logic                      o_turn_ready,
    output logic                      o_draw_req,
    input  logic                      i_draw_valid,
    input  uno_pkg::card_t            i_draw_card,
    output logic                      o_play_valid,
    output uno_pkg::card_t            o_play_card,
    input  logic                      i_play_ready,
    output logic [`UNO_COUNT_W-1:0]   o_hand_count
);

    uno_pkg::hand_t                   slots;
    logic [`UNO_HAND_SLOTS-1:0]       slot_used;
    logic                             full;
    uno_pkg::card_t                   top;
    logic                             found;
    logic [`UNO_SLOT_IDX_W-1:0]       sel_idx;
    uno_pkg::card_t                   sel_card;
    logic                             insert_valid;
    uno_pkg::card_t                   insert_card;
    logic                             remove_valid;
    logic [`UNO_SLOT_IDX_W-1:0]       remove_idx;

    uno_hand_store store_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_insert_valid (insert_valid),
        .i_insert_card  (insert_card),
        .i_remove_valid (remove_valid),
        .i_remove_idx   (remove_idx),
        .o_slots        (slots),
        .o_slot_used    (slot_used),
        .o_count        (o_hand_count),
        .o_full         (full)
    );

    uno_play_select select_i (
        .i_top       (top),
        .i_slots     (slots),
        .i_slot_used (slot_used),
        .o_found     (found),
        .o_idx       (sel_idx),
        .o_card      (sel_card)
    );

    uno_turn_ctrl ctrl_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_deal         (i_deal),
        .i_turn_valid   (i_turn_valid),
        .i_turn         (i_turn),
        .o_turn_ready   (o_turn_ready),
        .o_draw_req     (o_draw_req),
        .i_draw_valid   (i_draw_valid),
        .i_draw_card    (i_draw_card),
        .o_play_valid   (o_play_valid),
        .o_play_card    (o_play_card),
        .i_play_ready   (i_play_ready),
        .o_top          (top),
        .i_found        (found),
        .i_idx          (sel_idx),
        .i_card         (sel_card),
        .i_full         (full),
        .o_insert_valid (insert_valid),
        .o_insert_card  (insert_card),
        .o_remove_valid (remove_valid),
        .o_remove_idx   (remove_idx)
    );

endmodule

`default_nettype wire

// ==== logic/uno_turn_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uno_defs.svh"

module uno_turn_ctrl (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_deal,
    input  logic                          i_turn_valid,
    input  uno_pkg::turn_req_t            i_turn,
    output logic                          o_turn_ready,
    output logic                          o_draw_req,
    input  logic                          i_draw_valid,
    input  uno_pkg::card_t                i_draw_card,
    output logic                          o_play_valid,
    output uno_pkg::card_t                o_play_card,
    input  logic                          i_play_ready,
    output uno_pkg::card_t                o_top,
    input  logic                          i_found,
    input  logic [`UNO_SLOT_IDX_W-1:0]    i_idx,
    input  uno_pkg::card_t                i_card,
    input  logic                          i_full,
    output logic                          o_insert_valid,
    output uno_pkg::card_t                o_insert_card,
    output logic                          o_remove_valid,
    output logic [`UNO_SLOT_IDX_W-1:0]    o_remove_idx
);

    uno_pkg::ctrl_state_e             state_q;
    logic [`UNO_COUNT_W-1:0]          draw_cnt_q;  // cards still to draw
    uno_pkg::card_t                   top_q;
    uno_pkg::card_t                   play_card_q;
    logic [`UNO_SLOT_IDX_W-1:0]       play_idx_q;
    logic                             turn_hs;
    logic                             draw_hs;
    logic                             play_hs;

    assign o_turn_ready = (state_q == uno_pkg::st_idle);
    assign o_draw_req   = (state_q == uno_pkg::st_draw) && !i_full;
    assign o_play_valid = (state_q == uno_pkg::st_play);

    assign turn_hs = i_turn_valid && o_turn_ready;
    assign draw_hs = o_draw_req && i_draw_valid;
    assign play_hs = o_play_valid && i_play_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= uno_pkg::st_idle;
            draw_cnt_q <= '0;
        end else begin
            case (state_q)
                uno_pkg::st_idle: begin
                    if (turn_hs) begin
                        case (i_turn.penalty)
                            uno_pkg::pen_two: begin
                                draw_cnt_q <= `UNO_COUNT_W'(2);
                                state_q    <= uno_pkg::st_draw;
                            end
                            uno_pkg::pen_four: begin
                                draw_cnt_q <= `UNO_COUNT_W'(4);
                                state_q    <= uno_pkg::st_draw;
                            end
                            default: state_q <= uno_pkg::st_select;
                        endcase
                    end else if (i_deal) begin
                        draw_cnt_q <= `UNO_COUNT_W'(`UNO_DEAL_COUNT);
                        state_q    <= uno_pkg::st_draw;
                    end
                end
                uno_pkg::st_select: begin
                    if (i_found) begin
                        state_q <= uno_pkg::st_play;
                    end else begin
                        draw_cnt_q <= `UNO_COUNT_W'(1); // nothing matches, take one card
                        state_q    <= uno_pkg::st_draw;
                    end
                end
                uno_pkg::st_draw: begin
                    if (i_full) begin
                        state_q <= uno_pkg::st_idle; // no room, drop the rest
                    end else if (draw_hs) begin
                        draw_cnt_q <= draw_cnt_q - 1'b1;
                        if (draw_cnt_q == `UNO_COUNT_W'(1)) begin
                            state_q <= uno_pkg::st_idle;
                        end
                    end
                end
                uno_pkg::st_play: begin
                    if (play_hs) begin
                        state_q <= uno_pkg::st_idle;
                    end
                end
                default: state_q <= uno_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (turn_hs) begin
            top_q <= i_turn.top;
        end
        if ((state_q == uno_pkg::st_select) && i_found) begin
            play_card_q <= i_card;   // held stable through play back-pressure
            play_idx_q  <= i_idx;
        end
    end

    assign o_top          = top_q;
    assign o_play_card    = play_card_q;
    assign o_insert_valid = draw_hs;
    assign o_insert_card  = i_draw_card;
    assign o_remove_valid = play_hs;
    assign o_remove_idx   = play_idx_q;

endmodule

`default_nettype wire

// ==== logic/uno_play_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uno_defs.svh"

module uno_play_select (
    input  uno_pkg::card_t                i_top,
    input  uno_pkg::hand_t                i_slots,
    input  logic [`UNO_HAND_SLOTS-1:0]    i_slot_used,
    output logic                          o_found,
    output logic [`UNO_SLOT_IDX_W-1:0]    o_idx,
    output uno_pkg::card_t                o_card
);

    logic [`UNO_HAND_SLOTS-1:0]   col_hit;
    logic [`UNO_HAND_SLOTS-1:0]   rank_hit;
    logic [`UNO_HAND_SLOTS-1:0]   wild_hit;
    logic [`UNO_HAND_SLOTS-1:0]   four_hit;
    logic [`UNO_SLOT_IDX_W:0]     col_sel;
    logic [`UNO_SLOT_IDX_W:0]     rank_sel;
    logic [`UNO_SLOT_IDX_W:0]     wild_sel;
    logic [`UNO_SLOT_IDX_W:0]     four_sel;
    logic [`UNO_SLOT_IDX_W:0]     pick;
    logic [`UNO_COUNT_W-1:0]      col_cnt [4];
    logic                         top_ranked;
    uno_pkg::color_e              major;
    uno_pkg::card_t               sel_card;

    // numbers and coloured action cards, not wilds
    function automatic logic is_colour_card(input uno_pkg::card_t c);
        return c.rank <= uno_pkg::rank_draw_two;
    endfunction

    // returns {found, index} of the lowest set bit
    function automatic logic [`UNO_SLOT_IDX_W:0] lowest_hit(
        input logic [`UNO_HAND_SLOTS-1:0] hits
    );
        logic [`UNO_SLOT_IDX_W:0] res;
        res = '0;
        for (int i = `UNO_HAND_SLOTS-1; i >= 0; i--) begin
            if (hits[i]) begin
                res = {1'b1, `UNO_SLOT_IDX_W'(i)};
            end
        end
        return res;
    endfunction

    assign top_ranked = (i_top.rank <= uno_pkg::rank_draw_two); // a wild on top has no rank to match

    always_comb begin
        for (int i = 0; i < `UNO_HAND_SLOTS; i++) begin
            col_hit[i]  = i_slot_used[i] && is_colour_card(i_slots[i])
                          && (i_slots[i].color == i_top.color);
            rank_hit[i] = i_slot_used[i] && top_ranked && (i_slots[i].rank == i_top.rank);
            wild_hit[i] = i_slot_used[i] && (i_slots[i].rank == uno_pkg::rank_wild);
            four_hit[i] = i_slot_used[i] && (i_slots[i].rank == uno_pkg::rank_wild_four);
        end
    end

    assign col_sel  = lowest_hit(col_hit);
    assign rank_sel = lowest_hit(rank_hit);
    assign wild_sel = lowest_hit(wild_hit);
    assign four_sel = lowest_hit(four_hit);

    // colour census of the hand for a played wild
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            col_cnt[k] = '0;
        end
        for (int i = 0; i < `UNO_HAND_SLOTS; i++) begin
            if (i_slot_used[i] && is_colour_card(i_slots[i])) begin
                col_cnt[i_slots[i].color] = col_cnt[i_slots[i].color] + 1'b1;
            end
        end
        major = uno_pkg::col_red; // also the answer for an all-wild hand
        for (int c = 1; c < 4; c++) begin
            if (col_cnt[c] > col_cnt[major]) begin  // strict so ties keep the lower code
                major = uno_pkg::color_e'(2'(c));
            end
        end
    end

    always_comb begin
        if (col_sel[`UNO_SLOT_IDX_W]) begin
            pick = col_sel;
        end else if (rank_sel[`UNO_SLOT_IDX_W]) begin
            pick = rank_sel;
        end else if (wild_sel[`UNO_SLOT_IDX_W]) begin
            pick = wild_sel;
        end else begin
            pick = four_sel;
        end
        sel_card = i_slots[pick[`UNO_SLOT_IDX_W-1:0]];
        if (!is_colour_card(sel_card)) begin
            sel_card.color = major;
        end
    end

    assign o_found = pick[`UNO_SLOT_IDX_W];
    assign o_idx   = pick[`UNO_SLOT_IDX_W-1:0];
    assign o_card  = sel_card;

endmodule

`default_nettype wire

// ==== logic/uno_hand_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uno_defs.svh"

module uno_hand_store (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_insert_valid,
    input  uno_pkg::card_t               i_insert_card,
    input  logic                         i_remove_valid,
    input  logic [`UNO_SLOT_IDX_W-1:0]   i_remove_idx,
    output uno_pkg::hand_t               o_slots,
    output logic [`UNO_HAND_SLOTS-1:0]   o_slot_used,
    output logic [`UNO_COUNT_W-1:0]      o_count,
    output logic                         o_full
);

    uno_pkg::hand_t                 slots_q;
    logic [`UNO_HAND_SLOTS-1:0]     used_q;
    logic [`UNO_COUNT_W-1:0]        count_q;
    logic [`UNO_SLOT_IDX_W-1:0]     free_idx;
    logic                           free_found;
    logic                           ins_en;
    logic                           rem_en;

    // lowest unused slot
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        for (int i = `UNO_HAND_SLOTS-1; i >= 0; i--) begin
            if (!used_q[i]) begin
                free_idx   = `UNO_SLOT_IDX_W'(i);
                free_found = 1'b1;
            end
        end
    end

    assign ins_en = i_insert_valid && free_found;
    assign rem_en = i_remove_valid && used_q[i_remove_idx]; // ignore removes of empty slots

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            used_q  <= '0;
            count_q <= '0;
        end else begin
            if (ins_en) begin
                used_q[free_idx] <= 1'b1;
            end
            if (rem_en) begin
                used_q[i_remove_idx] <= 1'b0;
            end
            case ({ins_en, rem_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (ins_en) begin
            slots_q[free_idx] <= i_insert_card;
        end
        if (rem_en) begin
            slots_q[i_remove_idx] <= '0;
        end
    end

    assign o_slots     = slots_q;
    assign o_slot_used = used_q;
    assign o_count     = count_q;
    assign o_full      = (count_q == `UNO_COUNT_W'(`UNO_HAND_SLOTS));

endmodule

`default_nettype wire

// ==== logic/uno_pkg.sv ====
`default_nettype none

`include "uno_defs.svh"

package uno_pkg;

    typedef enum logic [1:0] {
        col_red    = 2'd0,
        col_yellow = 2'd1,
        col_green  = 2'd2,
        col_blue   = 2'd3
    } color_e;

    typedef enum logic [3:0] {
        rank_0        = 4'd0,
        rank_1        = 4'd1,
        rank_2        = 4'd2,
        rank_3        = 4'd3,
        rank_4        = 4'd4,
        rank_5        = 4'd5,
        rank_6        = 4'd6,
        rank_7        = 4'd7,
        rank_8        = 4'd8,
        rank_9        = 4'd9,
        rank_skip     = 4'd10,
        rank_reverse  = 4'd11,
        rank_draw_two = 4'd12,
        rank_wild     = 4'd13,
        rank_wild_four = 4'd14
    } rank_e;

    typedef struct packed {
        color_e color;
        rank_e  rank;
    } card_t;

    typedef enum logic [1:0] {
        pen_none = 2'd0,
        pen_two  = 2'd1,
        pen_four = 2'd2
    } penalty_e;

    typedef struct packed {
        card_t    top;     // top of the discard pile
        penalty_e penalty;
    } turn_req_t;

    typedef card_t [`UNO_HAND_SLOTS-1:0] hand_t;

    typedef enum logic [2:0] {
        st_idle,
        st_draw,
        st_select,
        st_play
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== logic/uno_defs.svh ====
`ifndef UNO_DEFS_SVH
`define UNO_DEFS_SVH

// hand capacity
`define UNO_HAND_SLOTS 20

// opening hand size
`define UNO_DEAL_COUNT 7

`define UNO_SLOT_IDX_W 5

// wide enough for a full hand of 20
`define UNO_COUNT_W 5

`endif
